/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_l2_pf_sm
FLIST     = all.f
BUILD     = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD)

/* all.f */
common/l2_pf_pkg.sv
design/l2_pf_ctrl.sv
design/l2_pf_addr_gen.sv
design/l2_pf_region_cmp.sv
design/l2_pf_sm.sv
tb/l2_pf_sm_checker.sv
tb/tb_l2_pf_sm.sv

/* common/l2_pf_pkg.sv */
// Shared types for the L2 prefetch address sequencer.
// Address width and page size are fixed here and used by every stage.
// The state encoding is fixed: bit 2 set means addresses may be compared.

`default_nettype none

package l2_pf_pkg;

  // ==========================================================
  // Address geometry
  // ==========================================================
  localparam int pa_width      = 40;
  localparam int page_offset_w = 12;
  localparam int ppn_width     = pa_width - page_offset_w;

  // Address or stride value
  typedef logic [pa_width-1:0]  pa_t;

  // Physical or virtual page number
  typedef logic [ppn_width-1:0] ppn_t;

  // ==========================================================
  // L2 prefetch state machine
  // ==========================================================
  // Upper half of the encoding holds the compare-enabled states
  typedef enum logic [2:0] {
    st_init_pf_addr = 3'b000,
    st_add_pf_va    = 3'b001,
    st_req_pf       = 3'b100,
    st_req_mmu      = 3'b101,
    st_wait_ppn     = 3'b110,
    st_dead         = 3'b111
  } l2_state_t;

endpackage

`default_nettype wire

/* design/l2_pf_addr_gen.sv */
// Address stage of the L2 prefetch sequencer.
// Holds the L2 virtual address plus the translated page and its attributes.
// The physical address reuses the in-page offset of the virtual address.
// cross_4k looks only at the low 13 stride bits, so strides must stay
// below one page in magnitude.

`timescale 1ns/1ps
`default_nettype none

module l2_pf_addr_gen
  import l2_pf_pkg::*;
(
  input  wire  entry_clk,
  input  wire  cpurst_b,
  input  wire  init_vld,
  input  wire  add_vld,
  input  wire  ppn_up_vld,
  input  pa_t  strideh,
  input  pa_t  inst_new_va,
  input  ppn_t ld_ppn,
  input  wire  ld_page_sec,
  input  wire  ld_page_share,
  input  ppn_t get_ppn,
  input  wire  get_page_sec,
  input  wire  get_page_share,
  output pa_t  pf_va,
  output pa_t  pf_addr,
  output ppn_t vpn,
  output logic page_sec,
  output logic page_share,
  output logic cross_4k
);

  ppn_t                   pf_ppn;
  pa_t                    va_next;
  logic [page_offset_w:0] offset_sum;

  // ==========================================================
  // Virtual address
  // ==========================================================
  assign va_next = pf_va + strideh;

  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pf_va <= '0;
    else if (init_vld)
      pf_va <= inst_new_va;
    else if (add_vld)
      pf_va <= va_next;
  end

  assign vpn = pf_va[pa_width-1:page_offset_w];

  // Carry out of the page offset
  assign offset_sum = {1'b0, pf_va[page_offset_w-1:0]} + strideh[page_offset_w:0];
  assign cross_4k   = offset_sum[page_offset_w];

  // ==========================================================
  // Page number and attributes
  // ==========================================================
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      pf_ppn     <= '0;
      page_sec   <= 1'b0;
      page_share <= 1'b0;
    end
    else if (init_vld)
    begin
      pf_ppn     <= ld_ppn;
      page_sec   <= ld_page_sec;
      page_share <= ld_page_share;
    end
    else if (ppn_up_vld)
    begin
      pf_ppn     <= get_ppn;
      page_sec   <= get_page_sec;
      page_share <= get_page_share;
    end
  end

  assign pf_addr = {pf_ppn, pf_va[page_offset_w-1:0]};

endmodule

`default_nettype wire

/* design/l2_pf_ctrl.sv */
// Control stage of the L2 prefetch sequencer.
// Pop, re-init or a low pref_en return the FSM to the start state.
// Request-set outputs are combinational and only rise while not pending.

`timescale 1ns/1ps
`default_nettype none

module l2_pf_ctrl
  import l2_pf_pkg::*;
(
  input  wire  entry_clk,
  input  wire  cpurst_b,
  input  wire  pref_en,
  input  wire  mmu_dis,
  input  wire  tsm_is_judge,
  input  wire  pop_vld,
  input  wire  reinit_vld,
  input  wire  biu_req_pending,
  input  wire  biu_grnt,
  input  wire  mmu_req_pending,
  input  wire  mmu_grnt,
  input  wire  get_ppn_vld,
  input  wire  get_ppn_err,
  input  wire  cross_4k,
  input  wire  in_region,
  output logic init_vld,
  output logic add_vld,
  output logic ppn_up_vld,
  output logic va_can_cmp,
  output logic biu_req_set,
  output logic mmu_req_set
);

  l2_state_t state;
  l2_state_t next_state;

  // ==========================================================
  // State register
  // ==========================================================
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= st_init_pf_addr;
    else if (pop_vld || reinit_vld || !pref_en)
      state <= st_init_pf_addr;
    else
      state <= next_state;
  end

  // ==========================================================
  // Next state
  // ==========================================================
  always_comb
  begin
    next_state = state;
    case (state)
      st_init_pf_addr:
        if (init_vld)
          next_state = st_add_pf_va;
      st_add_pf_va:
        next_state = st_req_pf;
      st_req_pf:
      begin
        // A step that leaves the page needs a fresh translation
        if (add_vld && cross_4k)
          next_state = mmu_dis ? st_dead : st_req_mmu;
      end
      st_req_mmu:
        if (mmu_grnt)
          next_state = st_wait_ppn;
      st_wait_ppn:
        if (get_ppn_vld)
          next_state = get_ppn_err ? st_dead : st_req_pf;
      // Parked until re-init, pop or a low pref_en
      st_dead:
        next_state = st_dead;
      default:
        next_state = st_init_pf_addr;
    endcase
  end

  // ==========================================================
  // Strobes
  // ==========================================================
  assign init_vld   = (state == st_init_pf_addr) && tsm_is_judge && pref_en;

  // First step follows the load and later steps follow each bus grant
  assign add_vld    = (state == st_add_pf_va) || biu_grnt;

  // A failed translation keeps the old page
  assign ppn_up_vld = (state == st_wait_ppn) && get_ppn_vld && !get_ppn_err;

  // Top state bit marks the compare-enabled states
  assign va_can_cmp = state[2];

  // Request pulses
  assign biu_req_set = (state == st_req_pf) && in_region && !biu_req_pending;
  assign mmu_req_set = (state == st_req_mmu) && !mmu_req_pending;

endmodule

`default_nettype wire

/* design/l2_pf_region_cmp.sv */
// Compare stage of the L2 prefetch sequencer.
// Flags use the sign of 40-bit differences, so the two streams must stay
// within half the address space of each other.
// stride_neg flips the sense of both flags for descending streams.

`timescale 1ns/1ps
`default_nettype none

module l2_pf_region_cmp
  import l2_pf_pkg::*;
(
  input  wire  entry_clk,
  input  wire  cpurst_b,
  input  pa_t  pf_va,
  input  pa_t  l1_pf_va,
  input  pa_t  dist_strideh,
  input  wire  stride_neg,
  input  wire  add_vld,
  input  wire  pf_inst_vld,
  input  wire  va_can_cmp,
  input  wire  create_dp_vld,
  input  wire  reinit_vld,
  output pa_t  va_sub_l1_va,
  output logic cmp_va_vld,
  output logic in_region,
  output logic reinit_req
);

  pa_t  diff_sub_dist;
  logic va_eq;
  logic surpass;
  logic surpass_set;
  logic in_region_set;

  // ==========================================================
  // Distance arithmetic
  // ==========================================================
  assign va_sub_l1_va  = pf_va - l1_pf_va;
  assign diff_sub_dist = va_sub_l1_va - dist_strideh;
  assign va_eq         = ~|va_sub_l1_va;

  // L1 ahead of L2 in the stream direction
  assign surpass_set   = (stride_neg ^ va_sub_l1_va[pa_width-1]) && !va_eq;

  // L2 still less than the distance ahead of L1
  assign in_region_set = stride_neg ^ diff_sub_dist[pa_width-1];

  // ==========================================================
  // Compare strobe and flags
  // ==========================================================
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cmp_va_vld <= 1'b0;
    else if (create_dp_vld || reinit_vld)
      cmp_va_vld <= 1'b0;
    else
      cmp_va_vld <= add_vld || (pf_inst_vld && va_can_cmp);
  end

  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      surpass   <= 1'b0;
      in_region <= 1'b1;
    end
    else if (create_dp_vld || reinit_vld)
    begin
      surpass   <= 1'b0;
      in_region <= 1'b1;
    end
    else if (cmp_va_vld && va_can_cmp)
    begin
      surpass   <= surpass_set;
      in_region <= in_region_set;
    end
  end

  assign reinit_req = va_can_cmp && surpass;

endmodule

`default_nettype wire

/* design/l2_pf_sm.sv */
// L2 prefetch address sequencer for one prefetch-buffer entry.
// All registers run on entry_clk, reset is asynchronous and active low.
// Grant inputs must already be qualified for this entry's L2 request.
// Holds a single stream at a time; there is no real pipeline.

`timescale 1ns/1ps
`default_nettype none

module l2_pf_sm
  import l2_pf_pkg::*;
(
  input  wire  entry_clk,
  input  wire  cpurst_b,
  input  wire  pref_en,
  input  wire  mmu_dis,
  input  wire  tsm_is_judge,
  input  wire  pop_vld,
  input  wire  reinit_vld,
  input  wire  create_dp_vld,
  input  wire  pf_inst_vld,
  input  wire  stride_neg,
  input  pa_t  strideh,
  input  pa_t  dist_strideh,
  input  pa_t  inst_new_va,
  input  pa_t  l1_pf_va,
  input  ppn_t ld_ppn,
  input  wire  ld_page_sec,
  input  wire  ld_page_share,
  input  wire  biu_req_pending,
  input  wire  biu_grnt,
  input  wire  mmu_req_pending,
  input  wire  mmu_grnt,
  input  wire  get_ppn_vld,
  input  wire  get_ppn_err,
  input  ppn_t get_ppn,
  input  wire  get_page_sec,
  input  wire  get_page_share,
  output logic biu_req_set,
  output logic mmu_req_set,
  output pa_t  pf_addr,
  output ppn_t vpn,
  output logic page_sec,
  output logic page_share,
  output logic cmp_va_vld,
  output logic va_can_cmp,
  output logic reinit_req,
  output pa_t  va_sub_l1_va
);

  // Strobes from the control stage
  logic init_vld;
  logic add_vld;
  logic ppn_up_vld;

  // Datapath feedback
  pa_t  pf_va;
  logic cross_4k;
  logic in_region;

  // ==========================================================
  // Control stage
  // ==========================================================
  l2_pf_ctrl ctrl_i (
    .entry_clk       (entry_clk),
    .cpurst_b        (cpurst_b),
    .pref_en         (pref_en),
    .mmu_dis         (mmu_dis),
    .tsm_is_judge    (tsm_is_judge),
    .pop_vld         (pop_vld),
    .reinit_vld      (reinit_vld),
    .biu_req_pending (biu_req_pending),
    .biu_grnt        (biu_grnt),
    .mmu_req_pending (mmu_req_pending),
    .mmu_grnt        (mmu_grnt),
    .get_ppn_vld     (get_ppn_vld),
    .get_ppn_err     (get_ppn_err),
    .cross_4k        (cross_4k),
    .in_region       (in_region),
    .init_vld        (init_vld),
    .add_vld         (add_vld),
    .ppn_up_vld      (ppn_up_vld),
    .va_can_cmp      (va_can_cmp),
    .biu_req_set     (biu_req_set),
    .mmu_req_set     (mmu_req_set)
  );

  // ==========================================================
  // Datapath stages
  // ==========================================================
  l2_pf_addr_gen addr_gen_i (
    .entry_clk      (entry_clk),
    .cpurst_b       (cpurst_b),
    .init_vld       (init_vld),
    .add_vld        (add_vld),
    .ppn_up_vld     (ppn_up_vld),
    .strideh        (strideh),
    .inst_new_va    (inst_new_va),
    .ld_ppn         (ld_ppn),
    .ld_page_sec    (ld_page_sec),
    .ld_page_share  (ld_page_share),
    .get_ppn        (get_ppn),
    .get_page_sec   (get_page_sec),
    .get_page_share (get_page_share),
    .pf_va          (pf_va),
    .pf_addr        (pf_addr),
    .vpn            (vpn),
    .page_sec       (page_sec),
    .page_share     (page_share),
    .cross_4k       (cross_4k)
  );

  l2_pf_region_cmp region_cmp_i (
    .entry_clk     (entry_clk),
    .cpurst_b      (cpurst_b),
    .pf_va         (pf_va),
    .l1_pf_va      (l1_pf_va),
    .dist_strideh  (dist_strideh),
    .stride_neg    (stride_neg),
    .add_vld       (add_vld),
    .pf_inst_vld   (pf_inst_vld),
    .va_can_cmp    (va_can_cmp),
    .create_dp_vld (create_dp_vld),
    .reinit_vld    (reinit_vld),
    .va_sub_l1_va  (va_sub_l1_va),
    .cmp_va_vld    (cmp_va_vld),
    .in_region     (in_region),
    .reinit_req    (reinit_req)
  );

endmodule

`default_nettype wire

/* tb/l2_pf_sm_checker.sv */
// Concurrent checks on the request and re-init outputs of the sequencer.
// Bound into every l2_pf_sm instance, checks are off while in reset.

`timescale 1ns/1ps
`default_nettype none

module l2_pf_sm_checker (
  input wire entry_clk,
  input wire cpurst_b,
  input wire biu_req_set,
  input wire mmu_req_set,
  input wire biu_req_pending,
  input wire mmu_req_pending,
  input wire reinit_req,
  input wire va_can_cmp
);

  // Only one request source at a time
  req_one_hot: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    !(biu_req_set && mmu_req_set))
    else $error("biu and mmu request pulses high together");

  biu_not_pending: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    biu_req_set |-> !biu_req_pending)
    else $error("biu request pulse while biu request pending");

  mmu_not_pending: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    mmu_req_set |-> !mmu_req_pending)
    else $error("mmu request pulse while mmu request pending");

  // Re-init only from a compare-enabled state
  reinit_in_cmp: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    reinit_req |-> va_can_cmp)
    else $error("reinit request outside a compare-enabled state");

endmodule

`default_nettype wire

/* tb/l2_pf_sm_vectors.txt */
# First data line: strideh dist_strideh inst_new_va ld_ppn get_ppn (hex)
# Then one line per cycle: in_bits l1_pf_va exp_bits mask pf_addr vpn (hex)
0000000040 0000000200 1234567F40 0ABCDEF 0FEDCBA
00000 0000000000 00 FF 0000000000 0000000
00105 1234567F40 00 FF 0000000000 0000000
00001 1234567F40 04 FF 0ABCDEFF40 1234567
00001 1234567F40 35 FF 0ABCDEFF80 1234567
00401 1234567F40 24 FF 0ABCDEFF80 1234567
00C01 1234567F40 24 FF 0ABCDEFF80 1234567
00001 1234567F40 35 FF 0ABCDEFFC0 1234567
00C01 1234567F40 24 FF 0ABCDEFFC0 1234567
00001 1234567F40 36 FF 0ABCDEF000 1234568
03001 1234567F40 24 FF 0ABCDEF000 1234568
24001 1234567F40 24 FF 0ABCDEF000 1234568
00001 1234567F40 29 FF 0FEDCBA000 1234568
00041 1234568100 29 FF 0FEDCBA000 1234568
00001 1234568100 39 FF 0FEDCBA000 1234568
00001 1234568100 69 FF 0FEDCBA000 1234568
00011 1234568100 69 FF 0FEDCBA000 1234568
00001 1234568100 08 FF 0FEDCBA000 1234568
00005 1234567F40 08 FF 0FEDCBA000 1234568
00001 1234567D00 00 FF 0ABCDEFF40 1234567
00001 1234567D00 31 FF 0ABCDEFF80 1234567
00001 1234567D00 20 FF 0ABCDEFF80 1234567
00801 1234567D00 20 FF 0ABCDEFF80 1234567
00001 1234567D00 30 FF 0ABCDEFFC0 1234567
00803 1234567D00 20 FF 0ABCDEFFC0 1234567
00003 1234567D00 30 FF 0ABCDEF000 1234568
00001 1234567D00 20 FF 0ABCDEF000 1234568
00011 1234567D00 20 FF 0ABCDEF000 1234568
00001 1234567D00 00 FF 0ABCDEF000 1234568
00005 1234567F40 00 FF 0ABCDEF000 1234568
00001 1234567F40 00 FF 0ABCDEFF40 1234567
00801 1234567F40 31 FF 0ABCDEFF80 1234567
00801 1234567F40 31 FF 0ABCDEFFC0 1234567
02001 1234567F40 32 FF 0ABCDEF000 1234568
0C001 1234567F40 20 FF 0ABCDEF000 1234568
00001 1234567F40 20 FF 0ABCDEF000 1234568
00000 1234567F40 20 FF 0ABCDEF000 1234568
00000 1234567F40 00 FF 0ABCDEF000 1234568

/* tb/tb_l2_pf_sm.sv */
// Vector-driven testbench for the L2 prefetch sequencer.
// Reads tb/l2_pf_sm_vectors.txt relative to the project root.
// Inputs change at the rising edge, outputs are checked at the falling edge.
// Stops at the first mismatch.

`timescale 1ns/1ps
`default_nettype none

module tb_l2_pf_sm
  import l2_pf_pkg::*;
();

  localparam int max_cycles = 200;
  localparam int max_lines  = 1000;

  logic entry_clk;
  logic cpurst_b;
  logic pref_en, mmu_dis, tsm_is_judge, pop_vld, reinit_vld, create_dp_vld;
  logic pf_inst_vld, stride_neg, ld_page_sec, ld_page_share;
  logic biu_req_pending, biu_grnt, mmu_req_pending, mmu_grnt;
  logic get_ppn_vld, get_ppn_err, get_page_sec, get_page_share;
  pa_t  strideh, dist_strideh, inst_new_va, l1_pf_va;
  ppn_t ld_ppn, get_ppn;
  logic biu_req_set, mmu_req_set, page_sec, page_share;
  logic cmp_va_vld, va_can_cmp, reinit_req;
  pa_t  pf_addr, va_sub_l1_va;
  ppn_t vpn;

  // Run configuration and per-cycle vectors
  pa_t         cfg_stride, cfg_dist, cfg_new_va;
  ppn_t        cfg_ld_ppn, cfg_get_ppn;
  logic [19:0] vec_in[$];
  pa_t         vec_l1[$];
  logic [7:0]  vec_exp[$];
  logic [7:0]  vec_mask[$];
  pa_t         vec_addr[$];
  ppn_t        vec_vpn[$];

  l2_pf_sm l2_pf_sm_i (.*);

  bind l2_pf_sm l2_pf_sm_checker checker_i (
    .entry_clk       (entry_clk),
    .cpurst_b        (cpurst_b),
    .biu_req_set     (biu_req_set),
    .mmu_req_set     (mmu_req_set),
    .biu_req_pending (biu_req_pending),
    .mmu_req_pending (mmu_req_pending),
    .reinit_req      (reinit_req),
    .va_can_cmp      (va_can_cmp)
  );

  always #10 entry_clk = ~entry_clk;

  // ============================================================
  // Reporting and compare tasks
  // ============================================================
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      fail_run("bit output differs");
    end
  endtask

  task automatic check_pa(input string name, input pa_t got, input pa_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      fail_run("address output differs");
    end
  endtask

  task automatic check_ppn(input string name, input ppn_t got, input ppn_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      fail_run("page number output differs");
    end
  endtask

  // ============================================================
  // Vector file reader
  // ============================================================
  task automatic read_vectors();
    int          fd;
    int          n;
    int          lines;
    bit          got_cfg;
    string       line;
    logic [19:0] ib;
    logic [7:0]  ex;
    logic [7:0]  mk;
    pa_t         l1;
    pa_t         pa;
    ppn_t        vp;
    fd = $fopen("tb/l2_pf_sm_vectors.txt", "r");
    if (fd == 0)
      fail_run("cannot open vector file tb/l2_pf_sm_vectors.txt");
    got_cfg = 1'b0;
    lines   = 0;
    while (!$feof(fd) && lines < max_lines)
    begin
      lines++;
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#")
      begin
        if (!got_cfg)
        begin
          n = $sscanf(line, "%h %h %h %h %h", cfg_stride, cfg_dist, cfg_new_va,
                      cfg_ld_ppn, cfg_get_ppn);
          got_cfg = (n == 5);
        end
        else if ($sscanf(line, "%h %h %h %h %h %h", ib, l1, ex, mk, pa, vp) == 6)
        begin
          vec_in.push_back(ib);
          vec_l1.push_back(l1);
          vec_exp.push_back(ex);
          vec_mask.push_back(mk);
          vec_addr.push_back(pa);
          vec_vpn.push_back(vp);
        end
      end
    end
    $fclose(fd);
    if (!got_cfg || vec_in.size() == 0)
      fail_run("vector file holds no configuration or no vectors");
  endtask

  task automatic apply_inputs(input logic [19:0] ib, input pa_t l1);
    pref_en         <= ib[0];
    mmu_dis         <= ib[1];
    tsm_is_judge    <= ib[2];
    pop_vld         <= ib[3];
    reinit_vld      <= ib[4];
    create_dp_vld   <= ib[5];
    pf_inst_vld     <= ib[6];
    stride_neg      <= ib[7];
    ld_page_sec     <= ib[8];
    ld_page_share   <= ib[9];
    biu_req_pending <= ib[10];
    biu_grnt        <= ib[11];
    mmu_req_pending <= ib[12];
    mmu_grnt        <= ib[13];
    get_ppn_vld     <= ib[14];
    get_ppn_err     <= ib[15];
    get_page_sec    <= ib[16];
    get_page_share  <= ib[17];
    l1_pf_va        <= l1;
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial
  begin
    int   i;
    int   cycles;
    logic [7:0] ex;
    logic [7:0] mk;
    pa_t  exp_va;
    entry_clk = 1'b0;
    cpurst_b  = 1'b0;
    apply_inputs('0, '0);
    strideh      = '0;
    dist_strideh = '0;
    inst_new_va  = '0;
    ld_ppn       = '0;
    get_ppn      = '0;
    read_vectors();
    strideh      = cfg_stride;
    dist_strideh = cfg_dist;
    inst_new_va  = cfg_new_va;
    ld_ppn       = cfg_ld_ppn;
    get_ppn      = cfg_get_ppn;
    repeat (10) @(posedge entry_clk);
    cpurst_b <= 1'b1;
    cycles = 0;
    for (i = 0; i < vec_in.size(); i++)
    begin
      if (cycles >= max_cycles)
        fail_run("timeout before the end of the vector file");
      @(posedge entry_clk);
      apply_inputs(vec_in[i], vec_l1[i]);
      @(negedge entry_clk);
      ex = vec_exp[i];
      mk = vec_mask[i];
      if (mk[0]) check_bit("biu_req_set", biu_req_set, ex[0]);
      if (mk[1]) check_bit("mmu_req_set", mmu_req_set, ex[1]);
      if (mk[2]) check_bit("page_sec", page_sec, ex[2]);
      if (mk[3]) check_bit("page_share", page_share, ex[3]);
      if (mk[4]) check_bit("cmp_va_vld", cmp_va_vld, ex[4]);
      if (mk[5]) check_bit("va_can_cmp", va_can_cmp, ex[5]);
      if (mk[6]) check_bit("reinit_req", reinit_req, ex[6]);
      if (mk[7])
      begin
        // L2 virtual address rebuilt from the expected page and offset
        exp_va = {vec_vpn[i], vec_addr[i][page_offset_w-1:0]} - vec_l1[i];
        check_pa("pf_addr", pf_addr, vec_addr[i]);
        check_ppn("vpn", vpn, vec_vpn[i]);
        check_pa("va_sub_l1_va", va_sub_l1_va, exp_va);
      end
      cycles++;
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire
